// File: rtl/booth_mul_pkg.sv
/*
 * Shared widths, vector types and structs for the radix-4 Booth multiplier.
 * Imported by wildcard in every RTL module of the multiplier.
 */
package booth_mul_pkg;

    // ------------------------------------------------------------------
    // widths and counts
    // ------------------------------------------------------------------
    localparam int OPERAND_W   = 32;
    localparam int PRODUCT_W   = 2 * OPERAND_W;
    // one row per Booth digit, plus one for the unsigned top digit
    localparam int NUM_PP      = OPERAND_W / 2 + 1;
    localparam int CLA_GROUP_W = 4;

    // ------------------------------------------------------------------
    // vector types
    // ------------------------------------------------------------------
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [PRODUCT_W-1:0] product_t;

    // row i is already shifted left by 2i
    typedef product_t [NUM_PP-1:0] pp_array_t;

    // ------------------------------------------------------------------
    // structs
    // ------------------------------------------------------------------
    typedef struct packed {
        logic     signed_mode;  // 1 = two's complement operands
        operand_t multiplicand;
        operand_t multiplier;
    } mul_req_t;

    // rows left for the final adder
    typedef struct packed {
        product_t sum;
        product_t carry;        // already weighted into place
    } sum_carry_t;

endpackage

// File: rtl/booth_pp_gen.sv
/*
 * Radix-4 Booth encoding of the multiplier and generation of the aligned,
 * sign-compressed partial-product rows that feed the reduction tree.
 */
`timescale 1ns/100ps

module booth_pp_gen
    import booth_mul_pkg::*;
(
    input  mul_req_t  req,
    output pp_array_t pps
);

    logic                 mcand_sign;
    logic                 mplier_sign;
    logic [OPERAND_W+1:0] mcand_ext;
    logic [OPERAND_W+2:0] mplier_ext;
    logic [NUM_PP-1:0]    neg;

    // ------------------------------------------------------------------
    // operand extension
    // ------------------------------------------------------------------
    assign mcand_sign  = req.signed_mode & req.multiplicand[OPERAND_W-1];
    assign mplier_sign = req.signed_mode & req.multiplier[OPERAND_W-1];

    // room for 2x the multiplicand without losing its sign
    assign mcand_ext  = {mcand_sign, mcand_sign, req.multiplicand};
    // bit 0 here is the implicit bit -1 of the first window
    assign mplier_ext = {mplier_sign, mplier_sign, req.multiplier, 1'b0};

    // ------------------------------------------------------------------
    // one Booth digit and one row per window
    // ------------------------------------------------------------------
    for (genvar i = 0; i < NUM_PP; i++)
    begin : g_row
        logic [2:0]           win;
        logic                 one;
        logic                 two;
        logic [OPERAND_W+1:0] mag;
        logic [OPERAND_W+1:0] pp;
        logic [OPERAND_W+3:0] ext_row;

        assign win = mplier_ext[2*i+2 -: 3];

        // digit -2..+2 as magnitude select and sign
        assign one    = win[0] ^ win[1];
        assign two    = (win[2] & ~win[1] & ~win[0]) | (~win[2] & win[1] & win[0]);
        // 111 is -0, treated as plain zero
        assign neg[i] = win[2] & ~(win[1] & win[0]);

        assign mag = one ? mcand_ext :
                     two ? {mcand_ext[OPERAND_W:0], 1'b0} :
                           '0;

        // one's complement here, the +1 lands in the next row
        assign pp = mag ^ {(OPERAND_W+2){neg[i]}};

        if (i == 0)
        begin : g_first
            // inverted sign then the sign twice
            assign ext_row = {~pp[OPERAND_W+1], pp[OPERAND_W+1], pp};
            assign pps[i]  = product_t'(ext_row);
        end
        else
        begin : g_rest
            // leading one then the inverted sign
            assign ext_row = {1'b0, 1'b1, ~pp[OPERAND_W+1], pp[OPERAND_W:0]};

            // previous row's negation bit in the vacant low bits
            // upper constant bits of late rows fall off above bit 63
            assign pps[i] = (product_t'(ext_row) << (2*i)) |
                            (product_t'(neg[i-1]) << (2*i-2));
        end
    end

    // top digit is never negative, so neg[NUM_PP-1] has no row to land in

endmodule

// File: rtl/csa_row_42.sv
/*
 * Full-width row of 4:2 compressors. Four aligned rows in, one sum row and
 * one carry row out, both aligned to the same weight.
 */
`timescale 1ns/100ps

module csa_row_42
    import booth_mul_pkg::*;
(
    input  product_t in_a,
    input  product_t in_b,
    input  product_t in_c,
    input  product_t in_d,
    output product_t sum,
    output product_t carry
);

    logic [PRODUCT_W-1:0] s1;
    logic [PRODUCT_W-1:0] hor_cout;
    logic [PRODUCT_W-1:0] hor_cin;
    logic [PRODUCT_W-1:0] carry_raw;

    // first full adder of every compressor
    assign s1       = in_a ^ in_b ^ in_c;
    assign hor_cout = (in_a & in_b) | (in_a & in_c) | (in_b & in_c);

    // horizontal carry from the position below
    // independent of that position's own cin, so no ripple
    assign hor_cin = {hor_cout[PRODUCT_W-2:0], 1'b0};

    // second full adder
    assign sum       = s1 ^ in_d ^ hor_cin;
    assign carry_raw = (s1 & in_d) | (s1 & hor_cin) | (in_d & hor_cin);

    // carry weighs one position up
    assign carry = {carry_raw[PRODUCT_W-2:0], 1'b0};

endmodule

// File: rtl/wallace_tree.sv
/*
 * Four-level reduction of the seventeen partial-product rows to one sum
 * row and one carry row, ready for the final adder.
 */
`timescale 1ns/100ps

module wallace_tree
    import booth_mul_pkg::*;
(
    input  pp_array_t  pps,
    output sum_carry_t result
);

    product_t lvl0_sum   [4];
    product_t lvl0_carry [4];
    product_t lvl1_sum   [2];
    product_t lvl1_carry [2];
    product_t lvl2_sum;
    product_t lvl2_carry;
    product_t last_pp;

    // ------------------------------------------------------------------
    // level 0: rows 0..15 in groups of four, row 16 waits
    // ------------------------------------------------------------------
    for (genvar k = 0; k < 4; k++)
    begin : g_lvl0
        csa_row_42 u_csa_l0
        (
            .in_a  (pps[4*k]),
            .in_b  (pps[4*k+1]),
            .in_c  (pps[4*k+2]),
            .in_d  (pps[4*k+3]),
            .sum   (lvl0_sum[k]),
            .carry (lvl0_carry[k])
        );
    end

    // ------------------------------------------------------------------
    // level 1: eight rows down to four
    // ------------------------------------------------------------------
    for (genvar k = 0; k < 2; k++)
    begin : g_lvl1
        csa_row_42 u_csa_l1
        (
            .in_a  (lvl0_sum[2*k]),
            .in_b  (lvl0_carry[2*k]),
            .in_c  (lvl0_sum[2*k+1]),
            .in_d  (lvl0_carry[2*k+1]),
            .sum   (lvl1_sum[k]),
            .carry (lvl1_carry[k])
        );
    end

    // ------------------------------------------------------------------
    // level 2: four rows down to two
    // ------------------------------------------------------------------
    csa_row_42 u_csa_l2
    (
        .in_a  (lvl1_sum[0]),
        .in_b  (lvl1_carry[0]),
        .in_c  (lvl1_sum[1]),
        .in_d  (lvl1_carry[1]),
        .sum   (lvl2_sum),
        .carry (lvl2_carry)
    );

    // ------------------------------------------------------------------
    // level 3: full adders fold in the passed-through last row
    // ------------------------------------------------------------------
    assign last_pp = pps[NUM_PP-1];

    assign result.sum = lvl2_sum ^ lvl2_carry ^ last_pp;

    // carries out of bit 63 are dropped, the sign-compression
    // constants rely on that wraparound
    assign result.carry = {((lvl2_sum[PRODUCT_W-2:0] & lvl2_carry[PRODUCT_W-2:0]) |
                            (lvl2_sum[PRODUCT_W-2:0] & last_pp[PRODUCT_W-2:0]) |
                            (lvl2_carry[PRODUCT_W-2:0] & last_pp[PRODUCT_W-2:0])),
                           1'b0};

endmodule

// File: rtl/cla_adder.sv
/*
 * Carry-lookahead adder of 4-bit lookahead groups with one lookahead
 * across all group carries. Carry-in is zero, no carry-out.
 */
`timescale 1ns/100ps

module cla_adder
    import booth_mul_pkg::*;
#(
    parameter int WIDTH = PRODUCT_W
)
(
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] sum
);

    logic [WIDTH-1:0]             gen;
    logic [WIDTH-1:0]             prop;
    logic [WIDTH-1:0]             carry;
    logic [WIDTH/CLA_GROUP_W-1:0] grp_gen;
    logic [WIDTH/CLA_GROUP_W-1:0] grp_prop;
    logic [WIDTH/CLA_GROUP_W-1:0] grp_cin;

    // per-bit generate and propagate
    assign gen  = a & b;
    assign prop = a ^ b;

    // ------------------------------------------------------------------
    // group generate and propagate
    // ------------------------------------------------------------------
    always_comb
    begin
        for (int j = 0; j < WIDTH/CLA_GROUP_W; j++)
        begin
            grp_gen[j]  = 1'b0;
            grp_prop[j] = 1'b1;
            for (int k = 0; k < CLA_GROUP_W; k++)
            begin
                grp_gen[j]  = gen[j*CLA_GROUP_W+k] |
                              (prop[j*CLA_GROUP_W+k] & grp_gen[j]);
                grp_prop[j] = grp_prop[j] & prop[j*CLA_GROUP_W+k];
            end
        end
    end

    // ------------------------------------------------------------------
    // lookahead across groups, sum of products per group carry
    // ------------------------------------------------------------------
    always_comb
    begin
        logic term;
        for (int j = 0; j < WIDTH/CLA_GROUP_W; j++)
        begin
            // carry-in of the whole adder is zero
            grp_cin[j] = 1'b0;
            for (int k = 0; k < j; k++)
            begin
                term = grp_gen[k];
                for (int m = k + 1; m < j; m++)
                begin
                    term = term & grp_prop[m];
                end
                grp_cin[j] = grp_cin[j] | term;
            end
        end
    end

    // carries inside each group
    always_comb
    begin
        for (int j = 0; j < WIDTH/CLA_GROUP_W; j++)
        begin
            carry[j*CLA_GROUP_W] = grp_cin[j];
            for (int k = 1; k < CLA_GROUP_W; k++)
            begin
                carry[j*CLA_GROUP_W+k] = gen[j*CLA_GROUP_W+k-1] |
                                         (prop[j*CLA_GROUP_W+k-1] & carry[j*CLA_GROUP_W+k-1]);
            end
        end
    end

    assign sum = prop ^ carry;

endmodule

// File: rtl/booth_mul_top.sv
/*
 * Two-stage pipelined 32-bit radix-4 Booth multiplier, signed or unsigned.
 * Product and out_valid follow a sampled request by two clock edges.
 */
`timescale 1ns/100ps

module booth_mul_top
    import booth_mul_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  mul_req_t req,
    output logic     out_valid,
    output product_t product
);

    pp_array_t  pps;
    sum_carry_t tree_out;
    sum_carry_t stage_q;
    logic       stage_valid_q;
    product_t   cla_sum;

    // ------------------------------------------------------------------
    // stage 1: partial products and reduction
    // ------------------------------------------------------------------
    booth_pp_gen u_pp_gen
    (
        .req (req),
        .pps (pps)
    );

    wallace_tree u_tree
    (
        .pps    (pps),
        .result (tree_out)
    );

    always_ff @(posedge clk)
    begin
        stage_q <= tree_out;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            stage_valid_q <= 1'b0;
        else
            stage_valid_q <= in_valid;
    end

    // ------------------------------------------------------------------
    // stage 2: final addition
    // ------------------------------------------------------------------
    cla_adder #(.WIDTH(PRODUCT_W)) u_cla
    (
        .a   (stage_q.sum),
        .b   (stage_q.carry),
        .sum (cla_sum)
    );

    // product holds between results
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            product   <= '0;
        end
        else
        begin
            out_valid <= stage_valid_q;
            if (stage_valid_q)
                product <= cla_sum;
        end
    end

endmodule

// File: verif/booth_mul_assertions.sv
/*
 * Concurrent checks on valid timing and product stability of the
 * multiplier top level, attached to it with bind.
 */
`timescale 1ns/100ps

module booth_mul_assertions
    import booth_mul_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     out_valid,
    input product_t product
);

    // number of failed assertions, read by the testbench at the end
    int unsigned fail_count = 0;

    // quiet under reset and on the first cycle after it
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !out_valid ##1 !out_valid)
        else
        begin
            $error("out_valid high during or right after reset");
            fail_count++;
        end

    // fixed two-edge latency when no reset came in between
    a_latency: assert property (@(posedge clk)
        ($past(rst_n) && $past(rst_n, 2)) |-> (out_valid == $past(in_valid, 2)))
        else
        begin
            $error("out_valid does not follow in_valid by two edges");
            fail_count++;
        end

    // product only moves with a result or a reset
    a_product_hold: assert property (@(posedge clk)
        ($past(rst_n) && !out_valid) |-> $stable(product))
        else
        begin
            $error("product changed while out_valid was low");
            fail_count++;
        end

    a_product_known: assert property (@(posedge clk)
        out_valid |-> !$isunknown(product))
        else
        begin
            $error("product has unknown bits while out_valid is high");
            fail_count++;
        end

endmodule

bind booth_mul_top booth_mul_assertions u_assertions
(
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .product   (product)
);

// File: verif/booth_mul_tb.sv
/*
 * Testbench for the pipelined Booth multiplier. Directed vectors come from
 * a data file, random requests follow, and a scoreboard checks each result.
 */
`timescale 1ns/100ps

module booth_mul_tb
    import booth_mul_pkg::*;
();

    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 16;
    localparam int DRIVE_DELAY      = 2;
    localparam int NUM_RANDOM       = 200;
    localparam int MAX_GAPS         = 50;
    localparam int PULSE_REQS       = 4;
    localparam int PULSE_RST_CYCLES = 3;
    localparam int POST_REQS        = 8;
    localparam int MARGIN_CYCLES    = 20;
    localparam int MAX_VECS         = 64;

    typedef struct packed {
        mul_req_t req;
        product_t expected;
    } vector_t;

    // one scoreboard entry per issued request
    typedef struct packed {
        product_t    expected;
        logic [31:0] due;
    } pending_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    mul_req_t    req;
    logic        out_valid;
    product_t    product;

    vector_t     vectors [MAX_VECS];
    int          vec_count;
    logic        vectors_loaded;
    pending_t    pending [$];
    pending_t    front;
    logic [31:0] cycle_cnt;
    integer      seed;
    int          errors;
    int          checked;
    int          gaps_used;
    product_t    last_product;
    logic        prev_rst_n;

    booth_mul_top dut_i
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .product   (product)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // full-width product of the extended operands wrapped to 64 bits
    function automatic product_t expected_product(input mul_req_t r);
        product_t a_ext;
        product_t b_ext;
        if (r.signed_mode)
        begin
            a_ext = {{OPERAND_W{r.multiplicand[OPERAND_W-1]}}, r.multiplicand};
            b_ext = {{OPERAND_W{r.multiplier[OPERAND_W-1]}}, r.multiplier};
        end
        else
        begin
            a_ext = {{OPERAND_W{1'b0}}, r.multiplicand};
            b_ext = {{OPERAND_W{1'b0}}, r.multiplier};
        end
        return a_ext * b_ext;
    endfunction

    task automatic load_vectors();
        integer      fd;
        int          n;
        string       line;
        logic [31:0] mode_word;
        operand_t    a;
        operand_t    b;
        product_t    e;
        vec_count = 0;
        fd = $fopen("verif/booth_mul_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("the vector file could not be opened");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && vec_count < MAX_VECS)
            begin
                n = $fgets(line, fd);
                // lines starting with # are column notes
                if (n > 0 && line.getc(0) != "#")
                begin
                    if ($sscanf(line, "%h %h %h %h", mode_word, a, b, e) == 4)
                    begin
                        vectors[vec_count].req.signed_mode  = mode_word[0];
                        vectors[vec_count].req.multiplicand = a;
                        vectors[vec_count].req.multiplier   = b;
                        vectors[vec_count].expected         = e;
                        vec_count++;
                    end
                end
            end
            $fclose(fd);
            if (vec_count == 0)
            begin
                $display("the vector file held no vectors");
                errors++;
            end
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic issue(input mul_req_t r, input product_t expected);
        pending_t entry;
        in_valid       = 1'b1;
        req            = r;
        entry.expected = expected;
        // checked at the negedge after the second edge from now
        entry.due      = cycle_cnt + 2;
        pending.push_back(entry);
    endtask

    task automatic issue_random();
        logic [31:0] rnd;
        mul_req_t    r;
        rnd            = $random(seed);
        r.signed_mode  = rnd[0];
        r.multiplicand = $random(seed);
        r.multiplier   = $random(seed);
        issue(r, expected_product(r));
    endtask

    // ------------------------------------------------------------------
    // scoreboard sampled at the falling edge
    // ------------------------------------------------------------------
    always @(negedge clk)
    begin
        if (out_valid === 1'b1)
        begin
            if (pending.size() == 0)
            begin
                $display("a result arrived at %0t with no request in flight", $time);
                errors++;
            end
            else
            begin
                front = pending.pop_front();
                checked++;
                if (product !== front.expected)
                begin
                    $display("** Error at %0t: product %h, expected %h",
                             $time, product, front.expected);
                    errors++;
                end
                if (cycle_cnt != front.due)
                begin
                    $display("a result came on cycle %0d but was due on cycle %0d",
                             cycle_cnt, front.due);
                    errors++;
                end
            end
        end
        else
        begin
            if (pending.size() != 0 && pending[0].due <= cycle_cnt)
            begin
                $display("a result due at %0t did not arrive", $time);
                front = pending.pop_front();
                errors++;
            end
            // product holds through gaps
            if (rst_n && prev_rst_n && product !== last_product)
            begin
                $display("** Error at %0t: product changed to %h, expected %h held",
                         $time, product, last_product);
                errors++;
            end
        end
        last_product = product;
        prev_rst_n   = rst_n;
    end

    initial
    begin
        wait (vectors_loaded);
        #((RESET_CYCLES + vec_count + NUM_RANDOM + MAX_GAPS + PULSE_REQS +
           PULSE_RST_CYCLES + POST_REQS + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout, results stopped arriving before all requests completed");
        $display("test failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial
    begin
        seed           = 32'hfe77dab7;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        req            = '0;
        cycle_cnt      = '0;
        errors         = 0;
        checked        = 0;
        gaps_used      = 0;
        prev_rst_n     = 1'b0;
        vectors_loaded = 1'b0;
        load_vectors();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int i = 0; i < vec_count; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            issue(vectors[i].req, vectors[i].expected);
        end

        // random requests on every cycle
        for (int i = 0; i < NUM_RANDOM / 2; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            issue_random();
        end

        // random requests with idle gaps
        for (int i = 0; i < NUM_RANDOM / 2; i++)
        begin
            if (gaps_used < MAX_GAPS && ($random(seed) & 3) == 0)
            begin
                @(posedge clk);
                #DRIVE_DELAY;
                in_valid = 1'b0;
                gaps_used++;
            end
            @(posedge clk);
            #DRIVE_DELAY;
            issue_random();
        end

        // reset pulse with requests in flight
        for (int i = 0; i < PULSE_REQS; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            issue_random();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        rst_n    = 1'b0;
        // the request sampled on the last edge is dropped here
        @(posedge clk);
        #1;
        pending.delete();
        repeat (PULSE_RST_CYCLES - 1) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        for (int i = 0; i < POST_REQS; i++)
        begin
            @(posedge clk);
            #DRIVE_DELAY;
            issue_random();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;

        while (pending.size() != 0)
        begin
            @(negedge clk);
        end
        // room for a stray extra result
        repeat (4) @(posedge clk);

        $display("%0d results checked, %0d errors, %0d assertion failures",
                 checked, errors, dut_i.u_assertions.fail_count);
        if (errors == 0 && dut_i.u_assertions.fail_count == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

// File: verif/booth_mul_vectors.txt
# columns: mode (1 = signed), multiplicand, multiplier, expected product
# all values in hex
0 00000000 00000000 0000000000000000
0 00000001 00000001 0000000000000001
0 ffffffff ffffffff fffffffe00000001
0 ffffffff 00000001 00000000ffffffff
0 aaaaaaaa ffffffff aaaaaaa955555556
0 55555555 ffffffff 55555554aaaaaaab
0 55555555 00000003 00000000ffffffff
0 aaaaaaaa 00000003 00000001fffffffe
0 80000000 80000000 4000000000000000
0 80000000 ffffffff 7fffffff80000000
0 00010000 00010000 0000000100000000
1 80000000 80000000 4000000000000000
1 80000000 ffffffff 0000000080000000
1 80000000 00000001 ffffffff80000000
1 ffffffff ffffffff 0000000000000001
1 ffffffff 00000001 ffffffffffffffff
1 7fffffff 7fffffff 3fffffff00000001
1 7fffffff 80000000 c000000080000000
1 fffffffe 00000003 fffffffffffffffa
1 00000005 fffffffd fffffffffffffff1
1 aaaaaaaa 00000002 ffffffff55555554
1 00000000 80000000 0000000000000000

// File: build.f
rtl/booth_mul_pkg.sv
rtl/booth_pp_gen.sv
rtl/csa_row_42.sv
rtl/wallace_tree.sv
rtl/cla_adder.sv
rtl/booth_mul_top.sv
verif/booth_mul_assertions.sv
verif/booth_mul_tb.sv

// File: Bender.yml
package:
  name: booth_mul

sources:
  - files:
      - rtl/booth_mul_pkg.sv
      - rtl/booth_pp_gen.sv
      - rtl/csa_row_42.sv
      - rtl/wallace_tree.sv
      - rtl/cla_adder.sv
      - rtl/booth_mul_top.sv
  - target: test
    files:
      - verif/booth_mul_assertions.sv
      - verif/booth_mul_tb.sv
